/* common/cpuPkg.sv */
package cpuPkg;

  // Widths and sizes
  localparam int wordBits     = 32;
  localparam int regCount     = 128;                    // Physical registers
  localparam int regIndexBits = $clog2(regCount);
  localparam logic [7:0] globalBase  = 8'd64;           // First global operand byte
  localparam logic [7:0] resetWindow = 8'd2;            // rPos after reset
  localparam int ramWords     = 256;
  localparam int ramIndexBits = $clog2(ramWords);
  localparam int ramLatency   = 2;                      // Seen strobe to acknowledge
  localparam int ramCountBits = $clog2(ramLatency + 1);

  // Opcodes, low byte of every instruction
  localparam logic [7:0] opNop    = 8'd0;
  localparam logic [7:0] opLoadi  = 8'd1;
  localparam logic [7:0] opAdd    = 8'd2;
  localparam logic [7:0] opSub    = 8'd3;
  localparam logic [7:0] opAnd    = 8'd4;
  localparam logic [7:0] opOr     = 8'd5;
  localparam logic [7:0] opXor    = 8'd6;
  localparam logic [7:0] opLoad   = 8'd7;
  localparam logic [7:0] opStore  = 8'd8;
  localparam logic [7:0] opJumpz  = 8'd9;
  localparam logic [7:0] opSetwin = 8'd10;
  localparam logic [7:0] opHalt   = 8'd255;

  // Sequencer modes
  localparam logic [2:0] modeFetch     = 3'd0;
  localparam logic [2:0] modeWaitFetch = 3'd1;
  localparam logic [2:0] modeReadRegs  = 3'd2;
  localparam logic [2:0] modeExecute   = 3'd3;
  localparam logic [2:0] modeMemory    = 3'd4;
  localparam logic [2:0] modeWaitMem   = 3'd5;
  localparam logic [2:0] modeRetire    = 3'd6;
  localparam logic [2:0] modeHalt      = 3'd7;

  typedef struct packed {
    logic [7:0] srcB;    // Bits 31:24
    logic [7:0] srcA;    // Bits 23:16
    logic [7:0] dest;    // Bits 15:8
    logic [7:0] opCode;  // Bits 7:0
  } regFormT;

  typedef struct packed {
    logic [15:0] imm16;  // Upper half
    logic [7:0]  target; // Same byte as dest
    logic [7:0]  opCode;
  } immFormT;

  // One instruction word, two views
  typedef union packed {
    regFormT regForm;
    immFormT immForm;
  } instrWordT;

  typedef struct packed {
    logic                readReq;
    logic                writeReq;
    logic [wordBits-1:0] address;   // Byte address
    logic [wordBits-1:0] writeData;
  } ramReqT;

  typedef struct packed {
    logic                readAck;
    logic                writeAck;
    logic [wordBits-1:0] readData;  // Valid with readAck
  } ramRespT;

  typedef struct packed {
    logic [7:0] dest;
    logic [7:0] srcA;
    logic [7:0] srcB;
  } operandsT;

  typedef struct packed {
    logic [wordBits-1:0] dest;
    logic [wordBits-1:0] srcA;
    logic [wordBits-1:0] srcB;
  } regValuesT;

  typedef struct packed {
    logic                enable;
    logic [7:0]          operand;   // Untranslated operand byte
    logic [wordBits-1:0] value;
  } regWriteT;

  typedef struct packed {
    logic       set;
    logic [7:0] base;
  } windowCmdT;

  typedef struct packed {
    logic                writesReg;
    logic [wordBits-1:0] value;
    logic                memRead;
    logic                memWrite;
    logic [wordBits-1:0] memAddress;
    logic                jumpTaken;
    logic [wordBits-1:0] jumpTarget;
    logic                setsWindow;
    logic                halt;
  } execResultT;

  typedef struct packed {
    logic                valid;
    logic [wordBits-1:0] ipointer;
    logic [7:0]          opCode;
    logic                writeEnable;
    logic [7:0]          dest;
    logic [wordBits-1:0] value;
  } retireT;

  typedef struct packed {
    logic                    enable;
    logic [ramIndexBits-1:0] index;  // Word index
    logic [wordBits-1:0]     data;
  } loadT;

endpackage

/* core/instrSequencer.sv */
`timescale 1ns/10ps

module instrSequencer import cpuPkg::*; (
  input  logic                clk,
  input  logic                reset,
  input  ramRespT             ramResp,
  output ramReqT              ramReq,
  output operandsT            operands,
  input  regValuesT           regValues,
  output regWriteT            regWrite,
  output windowCmdT           windowCmd,
  output instrWordT           instr,          // Latched instruction
  output logic [wordBits-1:0] ipointer,
  output regValuesT           latchedValues,
  input  execResultT          execResult,
  output retireT              retire,
  output logic                halted
);

  logic [2:0] mode;
  execResultT result;      // Latched in execute, value patched by LOAD
  instrWordT  fetchWord;   // Word whose operand bytes go to the window
  logic       memAccess;

  // Mode machine and instruction pointer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode     <= modeFetch;
      ipointer <= '0;
    end else begin
      case (mode)
        modeFetch: mode <= modeWaitFetch;            // Read strobe goes out now
        modeWaitFetch: begin
          if (ramResp.readAck) mode <= modeReadRegs;
        end
        modeReadRegs: mode <= modeExecute;           // Window values arrive here
        modeExecute: begin
          if (execResult.memRead || execResult.memWrite) begin
            mode <= modeMemory;
          end else begin
            mode <= modeRetire;
          end
        end
        modeMemory: mode <= modeWaitMem;             // Data strobe goes out now
        modeWaitMem: begin
          if (ramResp.readAck || ramResp.writeAck) mode <= modeRetire;
        end
        modeRetire: begin
          // Next instruction address
          if (result.jumpTaken) begin
            ipointer <= result.jumpTarget;
          end else begin
            ipointer <= ipointer + wordBits'(4);
          end
          mode <= result.halt ? modeHalt : modeFetch;
        end
        modeHalt: mode <= modeHalt;                  // Parked until reset
        default: mode <= modeFetch;
      endcase
    end
  end

  // Instruction, operand values and result
  always_ff @(posedge clk) begin
    if (mode == modeWaitFetch && ramResp.readAck) instr <= ramResp.readData;
    if (mode == modeReadRegs) latchedValues <= regValues;
    if (mode == modeExecute) result <= execResult;
    if (mode == modeWaitMem && ramResp.readAck) begin
      result.value <= ramResp.readData;  // LOAD data replaces the ALU value
    end
  end

  // Operand bytes follow the incoming word during the acknowledge
  // so the registered reads are ready in readRegs
  assign fetchWord = (mode == modeWaitFetch) ? instrWordT'(ramResp.readData) : instr;

  always_comb begin
    operands.dest = fetchWord.regForm.dest;
    operands.srcA = fetchWord.regForm.srcA;
    operands.srcB = fetchWord.regForm.srcB;
  end

  // RAM strobes for fetch and data access
  assign memAccess = (mode == modeMemory);

  always_comb begin
    ramReq.readReq   = ((mode == modeFetch) && !reset) || (memAccess && result.memRead);
    ramReq.writeReq  = memAccess && result.memWrite;
    ramReq.address   = (mode == modeFetch) ? ipointer : result.memAddress;
    ramReq.writeData = latchedValues.srcB;   // STORE data
  end

  // Retire side effects
  always_comb begin
    regWrite.enable  = (mode == modeRetire) && result.writesReg;
    regWrite.operand = instr.regForm.dest;   // Also the immediate target
    regWrite.value   = result.value;

    windowCmd.set  = (mode == modeRetire) && result.setsWindow;
    windowCmd.base = instr.immForm.imm16[7:0];

    retire.valid       = (mode == modeRetire);
    retire.ipointer    = ipointer;
    retire.opCode      = instr.regForm.opCode;
    retire.writeEnable = result.writesReg;
    retire.dest        = instr.regForm.dest;
    retire.value       = result.value;
  end

  // High from the HALT retire onward
  assign halted = (mode == modeHalt) || ((mode == modeRetire) && result.halt);

endmodule

/* core/registerWindow.sv */
`timescale 1ns/10ps

module registerWindow import cpuPkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  operandsT  operands,
  output regValuesT regValues,
  input  regWriteT  regWrite,
  input  windowCmdT windowCmd
);

  logic [wordBits-1:0] regs [regCount];
  logic [7:0]          rPos;              // Window base

  // Operand byte to physical register
  function automatic logic [regIndexBits-1:0] physIndex(
    input logic [7:0] operand,
    input logic [7:0] base
  );
    logic [7:0] index;
    if (operand >= globalBase) begin
      index = operand - globalBase;       // Global register
    end else begin
      index = operand + base;             // Relative to the window
    end
    return index[regIndexBits-1:0];       // Wraps modulo regCount
  endfunction

  // Window base
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rPos <= resetWindow;
    end else if (windowCmd.set) begin
      rPos <= windowCmd.base;
    end
  end

  // Array write and registered reads
  always_ff @(posedge clk) begin
    if (regWrite.enable) begin
      regs[physIndex(regWrite.operand, rPos)] <= regWrite.value;
    end
    regValues.dest <= regs[physIndex(operands.dest, rPos)];
    regValues.srcA <= regs[physIndex(operands.srcA, rPos)];
    regValues.srcB <= regs[physIndex(operands.srcB, rPos)];
  end

endmodule

/* cpuTop.f */
common/cpuPkg.sv
logic/wordRam.sv
logic/execUnit.sv
core/registerWindow.sv
core/instrSequencer.sv
logic/cpuTop.sv
test/cpuChecker.sv
test/cpuTb.sv

/* logic/cpuTop.sv */
`timescale 1ns/10ps

module cpuTop import cpuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  loadT   load,
  output retireT retire,
  output logic   halted
);

  ramReqT              ramReq;
  ramRespT             ramResp;
  operandsT            operands;
  regValuesT           regValues;
  regWriteT            regWrite;
  windowCmdT           windowCmd;
  instrWordT           instr;
  logic [wordBits-1:0] ipointer;
  regValuesT           latchedValues;
  execResultT          execResult;

  instrSequencer sequencer (
    .clk           (clk),
    .reset         (reset),
    .ramResp       (ramResp),
    .ramReq        (ramReq),
    .operands      (operands),
    .regValues     (regValues),
    .regWrite      (regWrite),
    .windowCmd     (windowCmd),
    .instr         (instr),
    .ipointer      (ipointer),
    .latchedValues (latchedValues),
    .execResult    (execResult),
    .retire        (retire),
    .halted        (halted)
  );

  registerWindow window (
    .clk       (clk),
    .reset     (reset),
    .operands  (operands),
    .regValues (regValues),
    .regWrite  (regWrite),
    .windowCmd (windowCmd)
  );

  execUnit exec (
    .instr    (instr),
    .values   (latchedValues),
    .ipointer (ipointer),
    .result   (execResult)
  );

  wordRam ram (
    .clk     (clk),
    .reset   (reset),
    .ramReq  (ramReq),
    .ramResp (ramResp),
    .load    (load)
  );

endmodule

/* logic/execUnit.sv */
`timescale 1ns/10ps

module execUnit import cpuPkg::*; (
  input  instrWordT           instr,
  input  regValuesT           values,
  input  logic [wordBits-1:0] ipointer,
  output execResultT          result
);

  logic [15:0]         imm;
  logic [wordBits-1:0] immSigned;

  assign imm       = instr.immForm.imm16;
  assign immSigned = {{(wordBits - 16){imm[15]}}, imm};

  always_comb begin
    result = '0;   // No effects unless the opcode says so
    case (instr.regForm.opCode)
      opNop: begin
      end
      opLoadi: begin
        result.writesReg = 1'b1;
        result.value     = immSigned;
      end
      // ALU ops read srcA and srcB in register form
      opAdd: begin
        result.writesReg = 1'b1;
        result.value     = values.srcA + values.srcB;
      end
      opSub: begin
        result.writesReg = 1'b1;
        result.value     = values.srcA - values.srcB;
      end
      opAnd: begin
        result.writesReg = 1'b1;
        result.value     = values.srcA & values.srcB;
      end
      opOr: begin
        result.writesReg = 1'b1;
        result.value     = values.srcA | values.srcB;
      end
      opXor: begin
        result.writesReg = 1'b1;
        result.value     = values.srcA ^ values.srcB;
      end
      opLoad: begin
        result.writesReg  = 1'b1;          // Value comes from RAM later
        result.memRead    = 1'b1;
        result.memAddress = values.srcA;
      end
      opStore: begin
        result.memWrite   = 1'b1;          // Data is srcB
        result.memAddress = values.srcA;
      end
      opJumpz: begin
        // Target register sits in the dest slot
        result.jumpTaken  = (values.dest == '0);
        result.jumpTarget = {ipointer[wordBits-1:16], imm};  // Within current 64 KB
      end
      opSetwin: result.setsWindow = 1'b1;  // Base taken from imm16
      opHalt:   result.halt       = 1'b1;
      default: begin
      end
    endcase
  end

endmodule

/* logic/wordRam.sv */
`timescale 1ns/10ps

module wordRam import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  ramReqT  ramReq,
  output ramRespT ramResp,
  input  loadT    load
);

  logic [wordBits-1:0]     mem [ramWords];
  logic [ramCountBits-1:0] countdown;     // Zero when idle
  logic                    readAck;
  logic                    writeAck;
  logic [wordBits-1:0]     readData;
  logic                    pendingWrite;  // Kind of access in flight
  logic [ramIndexBits-1:0] pendingIndex;
  logic [wordBits-1:0]     pendingData;
  logic                    strobe;
  logic                    finishing;

  assign strobe    = (ramReq.readReq || ramReq.writeReq) && (countdown == '0);
  assign finishing = (countdown == ramCountBits'(1));

  // Latency counter and acknowledges
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      countdown <= '0;
      readAck   <= 1'b0;
      writeAck  <= 1'b0;
    end else begin
      readAck  <= 1'b0;   // One-cycle pulses
      writeAck <= 1'b0;
      if (strobe) begin
        countdown <= ramCountBits'(ramLatency);
      end else if (countdown != '0) begin
        countdown <= countdown - ramCountBits'(1);
        if (finishing) begin
          readAck  <= !pendingWrite;
          writeAck <= pendingWrite;
        end
      end
    end
  end

  // Access capture, array and external load
  always_ff @(posedge clk) begin
    if (strobe) begin
      pendingWrite <= ramReq.writeReq;
      pendingIndex <= ramReq.address[ramIndexBits+1:2];  // Drop byte offset
      pendingData  <= ramReq.writeData;
    end
    if (finishing) begin
      if (pendingWrite) begin
        mem[pendingIndex] <= pendingData;
      end else begin
        readData <= mem[pendingIndex];
      end
    end
    if (reset && load.enable) mem[load.index] <= load.data;  // Program load
  end

  assign ramResp = '{readAck: readAck, writeAck: writeAck, readData: readData};

endmodule

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -f cpuTop.f --top-module cpuTb -o cpuSim &&
./obj_dir/cpuSim | tee /dev/stderr | grep -q "^Done: no errors$" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* test/cpuChecker.sv */
`timescale 1ns/10ps

module cpuChecker import cpuPkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  loadT   load,
  input  retireT retire,
  input  logic   halted,
  output int     valueErrors,
  output int     otherErrors,
  output int     retireCount
);

  logic [wordBits-1:0] memModel [ramWords];  // Mirrors RAM from the load port on
  logic [wordBits-1:0] regModel [regCount];
  logic [7:0]          winBase;              // Model rPos
  logic [wordBits-1:0] pc;                   // Next ipointer expected
  logic                haltSeen;
  int                  valueCount = 0;
  int                  otherCount = 0;
  int                  retires = 0;

  assign valueErrors = valueCount;
  assign otherErrors = otherCount;
  assign retireCount = retires;

  // Global bytes from 64 up, window-relative below
  function automatic logic [regIndexBits-1:0] regSlot(
    input logic [7:0] operand,
    input logic [7:0] base
  );
    if (operand >= globalBase) begin
      return regIndexBits'((int'(operand) - int'(globalBase)) % regCount);
    end
    return regIndexBits'((int'(operand) + int'(base)) % regCount);
  endfunction

  task automatic compareField(
    input string               name,
    input logic [wordBits-1:0] expected,
    input logic [wordBits-1:0] actual
  );
    if (actual !== expected) begin
      valueCount++;
      $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // Executes the word at pc in the model and checks the retire record
  task automatic checkRetire();
    logic [wordBits-1:0] w;
    logic [wordBits-1:0] a;
    logic [wordBits-1:0] b;
    logic [wordBits-1:0] t;
    logic [wordBits-1:0] value;
    logic [wordBits-1:0] nextPc;
    logic                writes;
    w      = memModel[pc[ramIndexBits+1:2]];
    a      = regModel[regSlot(w[23:16], winBase)];
    b      = regModel[regSlot(w[31:24], winBase)];
    t      = regModel[regSlot(w[15:8], winBase)];  // Jump test register
    writes = 1'b1;
    value  = '0;
    nextPc = pc + 32'd4;
    case (w[7:0])
      opLoadi: value = {{16{w[31]}}, w[31:16]};  // Sign-extended imm16
      opAdd:   value = a + b;
      opSub:   value = a - b;
      opAnd:   value = a & b;
      opOr:    value = a | b;
      opXor:   value = a ^ b;
      opLoad:  value = memModel[a[ramIndexBits+1:2]];
      opStore: begin
        writes = 1'b0;
        memModel[a[ramIndexBits+1:2]] = b;
      end
      opJumpz: begin
        writes = 1'b0;
        if (t == '0) nextPc = {16'h0000, w[31:16]};
      end
      opSetwin: begin
        writes  = 1'b0;
        winBase = w[23:16];                    // Low byte of imm16
      end
      opHalt: begin
        writes   = 1'b0;
        haltSeen = 1'b1;
      end
      default: writes = 1'b0;                  // Unknown acts as NOP
    endcase
    compareField("retire.ipointer", pc, retire.ipointer);
    compareField("retire.opCode", wordBits'(w[7:0]), wordBits'(retire.opCode));
    compareField("retire.writeEnable", wordBits'(writes), wordBits'(retire.writeEnable));
    compareField("retire.dest", wordBits'(w[15:8]), wordBits'(retire.dest));
    if (writes) begin
      compareField("retire.value", value, retire.value);
      regModel[regSlot(w[15:8], winBase)] = value;
    end
    pc = nextPc;
    retires++;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      if (load.enable) memModel[load.index] = load.data;  // Program image
      winBase  = resetWindow;
      pc       = '0;
      haltSeen = 1'b0;
    end else begin
      if (retire.valid) begin
        if (haltSeen) begin
          otherCount++;
          $display("Retire at %0d ns came after the core had halted", $time);
        end else begin
          checkRetire();
        end
      end
      if (halted && !haltSeen) begin
        otherCount++;
        $display("halted was high at %0d ns with no HALT retired", $time);
      end else if (!halted && haltSeen) begin
        otherCount++;
        $display("halted dropped at %0d ns after HALT retired", $time);
      end
    end
  end

endmodule

/* test/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb import cpuPkg::*; ();

  localparam int programRows = 25;
  localparam int haltTimeout = 2000;  // Cycles until halted must rise
  localparam int quietCycles = 60;    // Halted period watched for stray retires

  typedef struct packed {
    logic [wordBits-1:0] word;
    logic                retires;     // On the executed path
  } rowT;

  logic        clk;
  logic        reset;
  loadT        load;
  retireT      retire;
  logic        halted;
  rowT         progTable [programRows];
  logic [31:0] seed;
  int          valueErrors;
  int          otherErrors;
  int          retireCount;
  int          timeoutErrors;
  int          countErrors;
  int          expectedRetires;
  int          cycles;
  int          i;

  initial clk = 1'b0;
  always #50 clk = ~clk;  // 100 ns period

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] encodeReg(
    input logic [7:0] op,
    input logic [7:0] dest,
    input logic [7:0] srcA,
    input logic [7:0] srcB
  );
    return {srcB, srcA, dest, op};
  endfunction

  function automatic logic [31:0] encodeImm(
    input logic [7:0]  op,
    input logic [7:0]  target,
    input logic [15:0] imm
  );
    return {imm, target, op};
  endfunction

  task automatic buildProgram();
    int k;
    for (k = 0; k < programRows; k++) progTable[k] = '{word: '0, retires: 1'b1};
    seed = nextRandom(seed);
    progTable[0].word = encodeImm(opLoadi, 8'd1, seed[31:16]);
    seed = nextRandom(seed);
    progTable[1].word = encodeImm(opLoadi, 8'd2, seed[31:16]);
    // ADD, SUB, AND, OR, XOR on random picks of r1..r3
    for (k = 0; k < 5; k++) begin
      seed = nextRandom(seed);
      progTable[2 + k].word = encodeReg(opAdd + 8'(k), 8'(3 + k), 8'd1 + 8'(seed[16]),
                                        8'd1 + 8'(seed[25:24]) % 8'd3);
    end
    progTable[7].word = encodeReg(8'h33, 8'd1, 8'd1, 8'd2);  // Unknown opcode
    seed = nextRandom(seed);
    progTable[8].word  = encodeImm(opLoadi, 8'd64, seed[31:16]);  // Global 0
    progTable[9].word  = encodeImm(opSetwin, 8'd0, 16'd40);
    progTable[10].word = encodeReg(opAdd, 8'd1, 8'd64, 8'd64);
    progTable[11].word = encodeReg(opAdd, 8'd2, 8'd1, 8'd67);  // Old r1 seen as global 3
    progTable[12].word = encodeImm(opLoadi, 8'd4, 16'h0100);
    progTable[13].word = encodeReg(opStore, 8'd0, 8'd4, 8'd2);
    progTable[14].word = encodeReg(opLoad, 8'd5, 8'd4, 8'd0);   // Reads back the store
    progTable[15].word = encodeImm(opLoadi, 8'd6, 16'd96);      // Data row below
    progTable[16].word = encodeReg(opLoad, 8'd7, 8'd6, 8'd0);
    progTable[17].word = encodeImm(opLoadi, 8'd8, 16'h0000);
    progTable[18].word = encodeImm(opJumpz, 8'd8, 16'd84);      // Taken, skips two rows
    progTable[19]      = '{word: encodeImm(opHalt, 8'd0, 16'd0), retires: 1'b0};
    progTable[20]      = '{word: encodeImm(opLoadi, 8'd9, 16'h0001), retires: 1'b0};
    progTable[21].word = encodeImm(opJumpz, 8'd7, 16'd0);       // Not taken
    progTable[22].word = encodeReg(opXor, 8'd9, 8'd7, 8'd2);
    progTable[23].word = encodeImm(opHalt, 8'd0, 16'd0);
    progTable[24]      = '{word: 32'hA5C3_0F96, retires: 1'b0};  // Data word
  endtask

  cpuTop dut (
    .clk    (clk),
    .reset  (reset),
    .load   (load),
    .retire (retire),
    .halted (halted)
  );

  cpuChecker retireCheck (
    .clk         (clk),
    .reset       (reset),
    .load        (load),
    .retire      (retire),
    .halted      (halted),
    .valueErrors (valueErrors),
    .otherErrors (otherErrors),
    .retireCount (retireCount)
  );

  initial begin
    reset           = 1'b1;
    load            = '0;
    timeoutErrors   = 0;
    countErrors     = 0;
    expectedRetires = 0;
    seed            = 32'd61;
    buildProgram();
    // One row per falling edge while reset holds
    for (i = 0; i < programRows; i++) begin
      @(negedge clk);
      load.enable = 1'b1;
      load.index  = 8'(i);
      load.data   = progTable[i].word;
      expectedRetires += int'(progTable[i].retires);
    end
    @(negedge clk);
    load   = '0;
    cycles = programRows + 1;
    while (cycles < 8) begin  // Reset lasts 8 cycles at least
      @(negedge clk);
      cycles++;
    end
    reset  = 1'b0;
    cycles = 0;
    while (!halted && cycles < haltTimeout) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      timeoutErrors++;
      $display("Timeout: halted never rose within %0d cycles", haltTimeout);
    end else begin
      cycles = 0;
      while (cycles < quietCycles) begin  // Checker flags any retire here
        @(negedge clk);
        cycles++;
      end
      if (retireCount != expectedRetires) begin
        countErrors++;
        $display("** Error at %0d ns: retireCount expected %0d, got %0d",
                 $time, expectedRetires, retireCount);
      end
    end
    $display("Errors: %0d value, %0d protocol, %0d timeout",
             valueErrors + countErrors, otherErrors, timeoutErrors);
    if (valueErrors + otherErrors + timeoutErrors + countErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
